//--- hdl/t07_mmio_params.svh
`ifndef T07_MMIO_PARAMS_SVH
`define T07_MMIO_PARAMS_SVH

// bus widths
`define T07_DATA_W        32    // cpu data and address width

// address map, tested in this order by the decoder
`define T07_FETCH_TOP     1024  // last fetch address, inclusive
`define T07_TFT_TOP       2048  // first address past the tft window
`define T07_MEM_TOP       8192  // first address past data memory
`define T07_MEM_PREFIX    8'h33 // top byte of every memory address

// external memory model
`define T07_MEM_IDX_W     11    // word index bits, 2048 words
`define T07_MEM_LAT       3     // cycles from request to done

// register bank and tft frame
`define T07_REG_ADDR_W    5     // 32 registers
`define T07_TFT_ADDR_BITS 10    // address bits in front of each frame

`endif

//--- hdl/t07_mmio_pkg.sv
`default_nettype none

package t07_mmio_pkg;

    // access code driven by the cpu memory handler
    typedef enum logic [1:0] {
        CPU_IDLE    = 2'b00, // no access
        CPU_WRITE   = 2'b01, // store
        CPU_READ    = 2'b10, // load
        CPU_IDLE_HI = 2'b11  // also treated as idle
    } cpu_op_t;

    // operation code on the instruction/data memory port
    typedef enum logic [1:0] {
        MEM_READ_INSTR = 2'b00, // instruction fetch
        MEM_WRITE      = 2'b01, // data store
        MEM_READ_DATA  = 2'b10, // data load
        MEM_IDLE       = 2'b11  // nothing pending
    } mem_op_t;

endpackage

`default_nettype wire

//--- hdl/t07_mmio.sv
`timescale 1ns/1ps
`default_nettype none
`include "t07_mmio_params.svh"

module t07_mmio import t07_mmio_pkg::*; (
    input  wire                    clk,                   // only for checks
    input  wire                    reset,                 // only for checks
    input  wire [`T07_DATA_W-1:0]  addr_in,               // pc or load/store address
    input  wire [`T07_DATA_W-1:0]  mem_data_in,           // store data from cpu
    input  wire cpu_op_t           rwi_in,                // cpu access code
    input  wire [`T07_DATA_W-1:0]  ext_data_in,           // word from memory
    input  wire                    busy_o,                // memory still working
    input  wire [`T07_DATA_W-1:0]  reg_data_in,           // word from register bank
    input  wire                    ack_reg,               // register bank ack
    input  wire                    ack_tft,               // tft port ack
    output logic                   busy,                  // stall back to cpu
    output logic                   ri_out,                // register read request
    output logic [`T07_REG_ADDR_W-1:0] addr_out_reg,      // register index
    output logic                   wi_out,                // tft write request
    output logic [`T07_DATA_W-1:0] addr_out_tft,          // tft address
    output logic [`T07_DATA_W-1:0] write_data_out_tft,    // tft data
    output mem_op_t                rwi_out,               // memory operation
    output logic [`T07_DATA_W-1:0] addr_out,              // memory address
    output logic [`T07_DATA_W-1:0] write_data_out,        // memory store data
    output logic [`T07_DATA_W-1:0] ext_data_out,          // load result to cpu
    output logic [`T07_DATA_W-1:0] write_instruction_out  // fetched instruction
);

    always_comb begin
        busy                  = 1'b0;     // unmapped means no stall
        ri_out                = 1'b0;
        wi_out                = 1'b0;
        rwi_out               = MEM_IDLE;
        addr_out_reg          = '0;
        addr_out_tft          = '0;
        write_data_out_tft    = '0;
        addr_out              = '0;
        write_data_out        = '0;
        ext_data_out          = '0;
        write_instruction_out = '0;

        if (addr_in <= `T07_FETCH_TOP) begin                      // fetch ignores rwi_in
            busy                  = busy_o;
            rwi_out               = MEM_READ_INSTR;
            addr_out              = {`T07_MEM_PREFIX, addr_in[23:0]};
            write_instruction_out = ext_data_in;                  // straight to fetch stage
        end else if (addr_in < `T07_TFT_TOP) begin                // tft window takes writes only
            if (rwi_in == CPU_WRITE) begin
                busy               = !ack_tft;                    // request without ack
                wi_out             = 1'b1;
                addr_out_tft       = addr_in;
                write_data_out_tft = mem_data_in;
            end
        end else if (addr_in < `T07_MEM_TOP) begin                // data memory window
            if (rwi_in == CPU_WRITE) begin
                busy           = busy_o;
                rwi_out        = MEM_WRITE;
                addr_out       = {`T07_MEM_PREFIX, addr_in[23:0]};
                write_data_out = mem_data_in;
            end else if (rwi_in == CPU_READ) begin
                busy         = busy_o;
                rwi_out      = MEM_READ_DATA;
                addr_out     = {`T07_MEM_PREFIX, addr_in[23:0]};
                ext_data_out = ext_data_in;
            end
        end else if (rwi_in == CPU_READ) begin                    // register bank is read only
            busy         = !ack_reg;
            ri_out       = 1'b1;
            addr_out_reg = addr_in[`T07_REG_ADDR_W-1:0];          // low bits pick the register
            ext_data_out = reg_data_in;
        end
    end

    // at most one target holds a request or a pending ack
    one_target_a: assert property (@(posedge clk) disable iff (reset)
        $onehot0({ri_out || ack_reg, wi_out || ack_tft, rwi_out != MEM_IDLE}))
        else $error("more than one mmio target active");

    // cpu must hold the address until the stall drops
    addr_hold_a: assert property (@(posedge clk) disable iff (reset)
        busy |=> $stable(addr_in))
        else $error("addr_in changed while busy");

endmodule

`default_nettype wire

//--- hdl/t07_ext_memory.sv
`timescale 1ns/1ps
`default_nettype none
`include "t07_mmio_params.svh"

module t07_ext_memory import t07_mmio_pkg::*; (
    input  wire                    clk,
    input  wire                    reset,
    input  wire mem_op_t           rwi,        // operation from the decoder
    input  wire [`T07_DATA_W-1:0]  addr,       // prefixed byte address
    input  wire [`T07_DATA_W-1:0]  write_data, // store data
    output logic [`T07_DATA_W-1:0] read_data,  // word of the last read
    output logic                   busy_o      // operation not done yet
);

    localparam int DEPTH = 1 << `T07_MEM_IDX_W;       // words in the array
    localparam int CNT_W = $clog2(`T07_MEM_LAT + 1);  // latency counter width

    logic [`T07_DATA_W-1:0]   mem_array [DEPTH];      // instruction and data words
    logic [CNT_W-1:0]         lat_cnt;                // cycles spent on this op
    logic                     done;                   // op finished, wait for idle
    logic [`T07_MEM_IDX_W-1:0] word_idx;
    logic                     last_cycle;

    assign word_idx   = addr[`T07_MEM_IDX_W-1:0];     // fetch k and data 2048+k alias
    assign last_cycle = (lat_cnt == CNT_W'(`T07_MEM_LAT - 1));
    assign busy_o     = (rwi != MEM_IDLE) && !done;

    always_ff @(posedge clk) begin
        if (reset) begin
            lat_cnt <= '0;
            done    <= 1'b0;
        end else if (rwi == MEM_IDLE) begin           // ready for the next op
            lat_cnt <= '0;
            done    <= 1'b0;
        end else if (!done) begin
            if (last_cycle) begin
                lat_cnt <= '0;
                done    <= 1'b1;                      // busy_o drops after this edge
            end else begin
                lat_cnt <= lat_cnt + 1'b1;
            end
        end
    end

    // array access happens once, on the completing edge
    always_ff @(posedge clk) begin
        if (busy_o && last_cycle) begin
            if (rwi == MEM_WRITE) begin
                mem_array[word_idx] <= write_data;
            end else begin
                read_data <= mem_array[word_idx];     // both read codes
            end
        end
    end

    // the decoder must tag every access with the memory prefix
    prefix_a: assert property (@(posedge clk) disable iff (reset)
        (rwi != MEM_IDLE) |-> (addr[`T07_DATA_W-1 -: 8] == `T07_MEM_PREFIX))
        else $error("memory access without address prefix");

endmodule

`default_nettype wire

//--- hdl/t07_ext_registers.sv
`timescale 1ns/1ps
`default_nettype none
`include "t07_mmio_params.svh"

module t07_ext_registers (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       ri,         // read request, held until ack
    input  wire [`T07_REG_ADDR_W-1:0] addr,       // register index
    input  wire                       load_en,    // external load strobe
    input  wire [`T07_REG_ADDR_W-1:0] load_addr,  // index to load
    input  wire [`T07_DATA_W-1:0]     load_data,  // word to load
    output logic [`T07_DATA_W-1:0]    read_data,  // requested word
    output logic                      ack         // four-phase acknowledge
);

    localparam int DEPTH = 1 << `T07_REG_ADDR_W;  // 32 registers

    logic [`T07_DATA_W-1:0] bank [DEPTH];         // loaded from outside only

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                bank[i] <= '0;                    // bank starts empty
            end
            ack <= 1'b0;
        end else begin
            ack <= ri;                            // follows the request by one cycle
            if (load_en) begin
                bank[load_addr] <= load_data;
            end
        end
    end

    // word is captured on the same edge that raises ack
    always_ff @(posedge clk) begin
        if (ri && !ack) begin
            read_data <= bank[addr];
        end
    end

    // request may not be withdrawn before it was acknowledged
    req_hold_a: assert property (@(posedge clk) disable iff (reset)
        (ri && !ack) |=> ri)
        else $error("register request dropped before ack");

endmodule

`default_nettype wire

//--- hdl/t07_tft_spi.sv
`timescale 1ns/1ps
`default_nettype none
`include "t07_mmio_params.svh"

module t07_tft_spi (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   wi,    // write request from decoder
    input  wire [`T07_DATA_W-1:0] addr,  // low bits go out first
    input  wire [`T07_DATA_W-1:0] data,  // pixel or command word
    output logic                  ack,   // frame sent, held until wi drops
    output logic                  sclk,  // spi clock, idle low
    output logic                  mosi,  // serial data, msb first
    output logic                  cs     // chip select, active low
);

    localparam int FRAME_W = `T07_TFT_ADDR_BITS + `T07_DATA_W;  // 42 bits
    localparam int CNT_W   = $clog2(FRAME_W);

    typedef enum logic [1:0] {
        ST_IDLE,   // waiting for wi
        ST_SHIFT,  // frame on the wire
        ST_DONE    // ack high until wi falls
    } state_t;

    state_t             state;
    logic [FRAME_W-1:0] shift_q;   // address bits above data bits
    logic [CNT_W-1:0]   bit_cnt;   // bits already completed

    assign mosi = shift_q[FRAME_W-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ST_IDLE;
            bit_cnt <= '0;
            sclk    <= 1'b0;
            cs      <= 1'b1;
            ack     <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: if (wi) begin
                    state   <= ST_SHIFT;
                    cs      <= 1'b0;         // first bit is already on mosi
                    bit_cnt <= '0;
                end
                ST_SHIFT: if (!sclk) begin
                    sclk <= 1'b1;            // target samples here
                end else begin
                    sclk <= 1'b0;
                    if (bit_cnt == CNT_W'(FRAME_W - 1)) begin
                        state <= ST_DONE;
                        cs    <= 1'b1;
                        ack   <= 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                ST_DONE: if (!wi) begin
                    state <= ST_IDLE;
                    ack   <= 1'b0;           // four-phase return
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // load on request, shift on the falling side of sclk
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && wi) begin
            shift_q <= {addr[`T07_TFT_ADDR_BITS-1:0], data};
        end else if (state == ST_SHIFT && sclk) begin
            shift_q <= {shift_q[FRAME_W-2:0], 1'b0};
        end
    end

    // no clock edges reach the panel while it is deselected
    sclk_cs_a: assert property (@(posedge clk) disable iff (reset)
        sclk |-> !cs)
        else $error("tft sclk high with cs released");

endmodule

`default_nettype wire

//--- hdl/t07_mmio_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "t07_mmio_params.svh"

module t07_mmio_top import t07_mmio_pkg::*; (
    input  wire                       clk,
    input  wire                       reset,
    input  wire [`T07_DATA_W-1:0]     addr_in,               // cpu address
    input  wire [`T07_DATA_W-1:0]     mem_data_in,           // cpu store data
    input  wire cpu_op_t              rwi_in,                // cpu access code
    input  wire                       reg_load_en,           // register bank loader
    input  wire [`T07_REG_ADDR_W-1:0] reg_load_addr,
    input  wire [`T07_DATA_W-1:0]     reg_load_data,
    output logic                      busy,                  // cpu stall
    output logic [`T07_DATA_W-1:0]    ext_data_out,          // load result
    output logic [`T07_DATA_W-1:0]    write_instruction_out, // fetched word
    output logic                      tft_sclk,
    output logic                      tft_mosi,
    output logic                      tft_cs
);

    mem_op_t                    mem_rwi;    // decoder to memory
    logic [`T07_DATA_W-1:0]     mem_addr;
    logic [`T07_DATA_W-1:0]     mem_wdata;
    logic [`T07_DATA_W-1:0]     mem_rdata;  // memory back to decoder
    logic                       mem_busy;
    logic                       reg_ri;     // decoder to register bank
    logic [`T07_REG_ADDR_W-1:0] reg_addr;
    logic [`T07_DATA_W-1:0]     reg_rdata;
    logic                       reg_ack;
    logic                       tft_wi;     // decoder to tft port
    logic [`T07_DATA_W-1:0]     tft_addr;
    logic [`T07_DATA_W-1:0]     tft_data;
    logic                       tft_ack;

    t07_mmio u_mmio (
        .clk(clk), .reset(reset),
        .addr_in(addr_in), .mem_data_in(mem_data_in), .rwi_in(rwi_in),
        .ext_data_in(mem_rdata), .busy_o(mem_busy),
        .reg_data_in(reg_rdata), .ack_reg(reg_ack), .ack_tft(tft_ack),
        .busy(busy), .ri_out(reg_ri), .addr_out_reg(reg_addr),
        .wi_out(tft_wi), .addr_out_tft(tft_addr), .write_data_out_tft(tft_data),
        .rwi_out(mem_rwi), .addr_out(mem_addr), .write_data_out(mem_wdata),
        .ext_data_out(ext_data_out), .write_instruction_out(write_instruction_out)
    );

    t07_ext_memory u_memory (
        .clk(clk), .reset(reset), .rwi(mem_rwi), .addr(mem_addr),
        .write_data(mem_wdata), .read_data(mem_rdata), .busy_o(mem_busy)
    );

    t07_ext_registers u_registers (
        .clk(clk), .reset(reset), .ri(reg_ri), .addr(reg_addr),
        .load_en(reg_load_en), .load_addr(reg_load_addr), .load_data(reg_load_data),
        .read_data(reg_rdata), .ack(reg_ack)
    );

    t07_tft_spi u_tft (
        .clk(clk), .reset(reset), .wi(tft_wi), .addr(tft_addr), .data(tft_data),
        .ack(tft_ack), .sclk(tft_sclk), .mosi(tft_mosi), .cs(tft_cs)
    );

endmodule

`default_nettype wire

//--- sim/t07_mmio_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "t07_mmio_params.svh"

module t07_mmio_tb import t07_mmio_pkg::*; ();

    localparam int          MAX_LINES  = 64;
    localparam real         CLK_PERIOD = 100.0;
    localparam logic [31:0] PARK_ADDR  = 32'h0001_0000;  // unmapped when idle
    localparam int          FRAME_W    = `T07_TFT_ADDR_BITS + `T07_DATA_W;
    localparam logic [31:0] OP_WRITE   = 32'h0;
    localparam logic [31:0] OP_READ    = 32'h1;
    localparam logic [31:0] OP_FETCH   = 32'h2;
    localparam logic [31:0] OP_REGLOAD = 32'h3;
    localparam logic [31:0] OP_UNMAP   = 32'h4;
    localparam logic [31:0] OP_END     = 32'hff;

    logic        clk;
    logic        reset;
    logic [31:0] addr_in;
    logic [31:0] mem_data_in;
    cpu_op_t     rwi_in;
    logic        reg_load_en;
    logic [4:0]  reg_load_addr;
    logic [31:0] reg_load_data;
    logic        busy;
    logic [31:0] ext_data_out;
    logic [31:0] write_instruction_out;
    logic        tft_sclk;
    logic        tft_mosi;
    logic        tft_cs;

    logic [31:0]        stim [4*MAX_LINES];  // op, addr, data, expected per line
    logic [31:0]        reg_model [32];      // words loaded into the bank
    logic [31:0]        lfsr_state;
    int                 num_lines   = 0;
    logic [FRAME_W-1:0] frame       = '0;    // rebuilt from mosi
    int                 frame_bits  = 0;
    int                 frame_count = 0;

    t07_mmio_top UUT (
        .clk(clk), .reset(reset), .addr_in(addr_in), .mem_data_in(mem_data_in),
        .rwi_in(rwi_in), .reg_load_en(reg_load_en), .reg_load_addr(reg_load_addr),
        .reg_load_data(reg_load_data), .busy(busy), .ext_data_out(ext_data_out),
        .write_instruction_out(write_instruction_out),
        .tft_sclk(tft_sclk), .tft_mosi(tft_mosi), .tft_cs(tft_cs)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(negedge tft_cs) begin  // start of a frame
        frame_bits  = 0;
        frame_count = frame_count + 1;
    end

    always @(posedge tft_sclk) begin
        if (!tft_cs) begin
            frame      = {frame[FRAME_W-2:0], tft_mosi};  // msb arrives first
            frame_bits = frame_bits + 1;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];  // taps 32 22 2 1
        return {s[30:0], fb};
    endfunction

    task automatic random_word(output logic [31:0] word);
        word = '0;
        for (int b = 0; b < 32; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            word       = {word[30:0], lfsr_state[0]};  // one step per bit
        end
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("error: %s is %h, expected %h", name, got, exp));
        end
    endtask

    // one cpu access, held until busy drops, result sampled on that falling edge
    task automatic cpu_access(input logic [31:0] addr, input cpu_op_t code,
                              input logic [31:0] data, output int cycles);
        @(posedge clk);
        addr_in     <= addr;
        rwi_in      <= code;
        mem_data_in <= data;
        cycles = 0;
        @(negedge clk);
        while (busy) begin
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic park_bus();
        @(posedge clk);
        addr_in     <= PARK_ADDR;
        rwi_in      <= CPU_IDLE;
        mem_data_in <= '0;
        @(posedge clk);  // next access drives one edge later
    endtask

    task automatic run_line(input logic [31:0] op, input logic [31:0] addr,
                            input logic [31:0] data, input logic [31:0] exp);
        int          cycles;
        int          frames_before;
        logic [31:0] word;
        frames_before = frame_count;
        case (op)
            OP_REGLOAD: begin
                word = data;
                if (data == 0) random_word(word);  // zero in the file means random
                @(posedge clk);
                reg_load_en   <= 1'b1;
                reg_load_addr <= addr[4:0];
                reg_load_data <= word;
                @(posedge clk);
                reg_load_en <= 1'b0;
                reg_model[addr[4:0]] = word;
            end
            OP_WRITE: begin
                cpu_access(addr, CPU_WRITE, data, cycles);
                if (addr > `T07_FETCH_TOP && addr < `T07_TFT_TOP) begin
                    check_value("tft busy cycles", cycles, 2 * FRAME_W + 1);  // 2 per bit + load
                    check_value("tft_cs", tft_cs, 1);
                    check_value("tft frame bits", frame_bits, FRAME_W);
                    check_value("tft frame", frame, {addr[`T07_TFT_ADDR_BITS-1:0], data});
                    check_value("tft frame count", frame_count - frames_before, 1);
                end else begin
                    check_value("mem write busy cycles", cycles, `T07_MEM_LAT);
                end
                park_bus();
            end
            OP_READ: begin
                cpu_access(addr, CPU_READ, '0, cycles);
                if (addr >= `T07_MEM_TOP) begin
                    word = (exp != 0) ? exp : reg_model[addr[4:0]];
                    check_value("reg read busy cycles", cycles, 1);
                end else begin
                    word = exp;
                    check_value("mem read busy cycles", cycles, `T07_MEM_LAT);
                end
                check_value("ext_data_out", ext_data_out, word);
                check_value("write_instruction_out", write_instruction_out, 0);
                park_bus();
            end
            OP_FETCH: begin
                cpu_access(addr, CPU_IDLE, '0, cycles);  // fetch ignores the code
                check_value("fetch busy cycles", cycles, `T07_MEM_LAT);
                check_value("write_instruction_out", write_instruction_out, exp);
                check_value("ext_data_out", ext_data_out, 0);
                park_bus();
            end
            OP_UNMAP: begin
                cpu_access(addr, (addr < `T07_TFT_TOP) ? CPU_READ : CPU_WRITE, data, cycles);
                check_value("unmapped busy cycles", cycles, 0);
                check_value("ext_data_out", ext_data_out, 0);
                check_value("write_instruction_out", write_instruction_out, 0);
                park_bus();
                check_value("tft frame count", frame_count - frames_before, 0);
            end
            default: fail_run($sformatf("unknown operation %h in the stimulus file", op));
        endcase
    endtask

    initial begin
        int n;
        reset         = 1'b1;
        addr_in       = PARK_ADDR;
        rwi_in        = CPU_IDLE;
        mem_data_in   = '0;
        reg_load_en   = 1'b0;
        reg_load_addr = '0;
        reg_load_data = '0;
        lfsr_state    = 32'hca09;
        for (int i = 0; i < 32; i++) reg_model[i] = '0;  // bank is cleared by reset
        $readmemh("sim/t07_mmio_stim.txt", stim);
        n = 0;
        while (n < MAX_LINES && stim[4*n] != OP_END) n++;
        if (n == 0 || n == MAX_LINES) fail_run("stimulus file is empty or has no end marker");
        num_lines = n;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("busy", busy, 0);
        check_value("ext_data_out", ext_data_out, 0);
        check_value("write_instruction_out", write_instruction_out, 0);
        check_value("tft_cs", tft_cs, 1);
        check_value("tft_sclk", tft_sclk, 0);
        for (int i = 0; i < num_lines; i++) begin
            run_line(stim[4*i], stim[4*i+1], stim[4*i+2], stim[4*i+3]);
        end
        $display("TB PASSED");
        $finish;
    end

    initial begin  // watchdog, 100 cycles per stimulus line
        wait (num_lines > 0);
        #(num_lines * 100 * CLK_PERIOD);
        fail_run($sformatf("timeout: stimulus not finished within %0d clock cycles",
                           num_lines * 100));
    end

endmodule

`default_nettype wire

//--- sim/t07_mmio_stim.txt
// op addr data expected, all hex; op 0 write 1 read 2 fetch 3 regload 4 unmapped ff end
// regload: addr is the index, data 0 takes a random word; register reads with expected 0 use the loaded word
0 00000800 a5a50001 00000000
1 00000800 00000000 a5a50001
0 00000a00 deadbeef 00000000
2 00000200 00000000 deadbeef
2 00000000 00000000 a5a50001
0 00001ffc 13579bdf 00000000
1 00001ffc 00000000 13579bdf
0 00000c00 cafef00d 00000000
2 00000400 00000000 cafef00d
3 00000005 00000000 00000000
3 0000001f 89abcdef 00000000
1 00002005 00000000 00000000
1 0000201f 00000000 89abcdef
1 00002003 00000000 00000000
0 00000401 0badc0de 00000000
0 000007ff 12345678 00000000
4 00000500 00000000 00000000
4 00002000 feedface 00000000
1 00000a00 00000000 deadbeef
ff 00000000 00000000 00000000

//--- src.f
+incdir+hdl
hdl/t07_mmio_pkg.sv
hdl/t07_mmio.sv
hdl/t07_ext_memory.sv
hdl/t07_ext_registers.sv
hdl/t07_tft_spi.sv
hdl/t07_mmio_top.sv
sim/t07_mmio_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the t07 mmio testbench with verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator is not installed"
    exit 1
fi

if ! verilator --binary --timing --assert --top-module t07_mmio_tb \
        -Mdir "$build_dir" -f src.f; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/Vt07_mmio_tb" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "TB FAILED" "$log_file"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ "$run_status" -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
exit 0
